// File: src/acc_disp_pkg.sv
/*
 * Shared encodings and widths for the accelerator dispatch unit.
 * Every block imports this package to agree on functional unit codes,
 * accelerator operation kinds, transaction ID width and data widths.
 */
package acc_disp_pkg;

  // Scoreboard geometry
  localparam int unsigned NR_SB_ENTRIES = 8;
  localparam int unsigned TRANS_ID_BITS = 3;

  // Datapath widths
  localparam int unsigned XLEN   = 64;
  localparam int unsigned INSN_W = 32;

  // Functional unit of the instruction at the issue port
  typedef enum logic [1:0] {
    FU_NONE  = 2'd0,
    FU_LOAD  = 2'd1,
    FU_STORE = 2'd2,
    FU_ACCEL = 2'd3
  } fu_e;

  // Memory behaviour of an accelerator instruction
  typedef enum logic [1:0] {
    ACC_OP_COMPUTE = 2'd0,
    ACC_OP_LOAD    = 2'd1,
    ACC_OP_STORE   = 2'd2
  } acc_op_e;

  // Floating-point rounding mode as held in fcsr
  typedef logic [2:0] frm_t;

  // Cause reported when the coprocessor flags an error
  localparam logic [XLEN-1:0] EXC_ILLEGAL_INSN = 64'd2;

endpackage

// File: src/acc_insn_queue.sv
/*
 * Fall-through circular FIFO holding decoded accelerator instructions.
 * Push data shows on the head outputs in the same cycle when empty.
 * The usage count feeds the issue stall, flush drops every entry.
 */
module acc_insn_queue #(
  parameter int unsigned QUEUE_DEPTH = 3
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     flush_i,
  input  logic                                     push_i,
  input  acc_disp_pkg::acc_op_e                    push_op_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0]   push_trans_id_i,
  input  logic [acc_disp_pkg::INSN_W-1:0]          push_insn_i,
  input  logic [acc_disp_pkg::XLEN-1:0]            push_rs1_i,
  input  logic [acc_disp_pkg::XLEN-1:0]            push_rs2_i,
  input  logic                                     pop_i,
  output logic                                     empty_o,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0]         usage_o,
  output acc_disp_pkg::acc_op_e                    head_op_o,
  output logic [acc_disp_pkg::TRANS_ID_BITS-1:0]   head_trans_id_o,
  output logic [acc_disp_pkg::INSN_W-1:0]          head_insn_o,
  output logic [acc_disp_pkg::XLEN-1:0]            head_rs1_o,
  output logic [acc_disp_pkg::XLEN-1:0]            head_rs2_o
);
  import acc_disp_pkg::*;

  localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH+1);

  acc_op_e                  op_mem   [QUEUE_DEPTH];
  logic [TRANS_ID_BITS-1:0] id_mem   [QUEUE_DEPTH];
  logic [INSN_W-1:0]        insn_mem [QUEUE_DEPTH];
  logic [XLEN-1:0]          rs1_mem  [QUEUE_DEPTH];
  logic [XLEN-1:0]          rs2_mem  [QUEUE_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             is_empty, wr_en, rd_en;

  assign is_empty = (cnt_q == '0);
  // A push straight into a pop while empty bypasses storage
  assign wr_en = push_i && !(is_empty && pop_i) && (cnt_q != CNT_W'(QUEUE_DEPTH));
  assign rd_en = pop_i && !is_empty;

  assign empty_o = is_empty && !push_i;
  assign usage_o = cnt_q;

  // Head view, falls through to the push data when storage is empty
  assign head_op_o       = is_empty ? push_op_i       : op_mem[rd_ptr_q];
  assign head_trans_id_o = is_empty ? push_trans_id_i : id_mem[rd_ptr_q];
  assign head_insn_o     = is_empty ? push_insn_i     : insn_mem[rd_ptr_q];
  assign head_rs1_o      = is_empty ? push_rs1_i      : rs1_mem[rd_ptr_q];
  assign head_rs2_o      = is_empty ? push_rs2_i      : rs2_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (wr_en && !flush_i) begin
      op_mem[wr_ptr_q]   <= push_op_i;
      id_mem[wr_ptr_q]   <= push_trans_id_i;
      insn_mem[wr_ptr_q] <= push_insn_i;
      rs1_mem[wr_ptr_q]  <= push_rs1_i;
      rs2_mem[wr_ptr_q]  <= push_rs2_i;
    end
  end

endmodule

// File: src/acc_spec_tracker.sv
/*
 * Tracks which accelerator transaction IDs are no longer speculative.
 * Received IDs wait in the pending map until the commit stage names them,
 * then sit in the ready map until the request stage dispatches them.
 */
module acc_spec_tracker (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   flush_i,
  input  logic                                   recv_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] recv_trans_id_i,
  input  logic                                   commit_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] commit_trans_id_i,
  input  logic                                   dispatch_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] dispatch_trans_id_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] query_trans_id_i,
  output logic                                   ready_o
);
  import acc_disp_pkg::*;

  logic [NR_SB_ENTRIES-1:0] pending_d, pending_q;
  logic [NR_SB_ENTRIES-1:0] ready_d, ready_q;
  logic                     commit_hit;

  // Commit only counts for an ID this unit actually holds
  assign commit_hit = commit_i && pending_q[commit_trans_id_i];

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    if (recv_i) begin
      pending_d[recv_trans_id_i] = 1'b1;
    end
    // Flushed instructions never become ready
    if (flush_i) begin
      pending_d = '0;
    end
    if (commit_hit) begin
      pending_d[commit_trans_id_i] = 1'b0;
      ready_d[commit_trans_id_i]   = 1'b1;
    end
    // Dispatch wins over a same-cycle commit of that ID
    if (dispatch_i) begin
      ready_d[dispatch_trans_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  // Head is ready, or is committing right now
  assign ready_o = ready_q[query_trans_id_i] ||
                   (commit_hit && (commit_trans_id_i == query_trans_id_i));

endmodule

// File: src/acc_mem_tracker.sv
/*
 * Load and store bookkeeping for memory consistency mode.
 * Counts speculative and dispatched coprocessor accesses, stalls conflicting
 * scalar loads and stores, and halts the core on a store barrier.
 */
module acc_mem_tracker #(
  parameter int unsigned CNT_WIDTH = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  logic                  cons_en_i,
  input  acc_disp_pkg::fu_e     issue_fu_i,
  input  logic                  issue_accept_i,
  input  acc_disp_pkg::acc_op_e issue_op_i,
  input  logic                  ld_disp_i,
  input  logic                  st_disp_i,
  input  logic                  load_complete_i,
  input  logic                  store_complete_i,
  input  logic                  store_pending_i,
  input  logic                  st_barrier_i,
  output logic                  mem_stall_o,
  output logic                  halt_o
);
  import acc_disp_pkg::*;

  logic [CNT_WIDTH-1:0] spec_ld_q, spec_st_q, disp_ld_q, disp_st_q;
  logic                 ld_pending, st_pending;
  logic                 ld_accept, st_accept;
  logic                 wait_st_q;

  // Up/down step shared by all four counters, wraps on overflow
  function automatic logic [CNT_WIDTH-1:0] step(input logic [CNT_WIDTH-1:0] cnt,
                                                input logic up,
                                                input logic down);
    logic [CNT_WIDTH-1:0] res;
    res = cnt;
    if (up && !down) begin
      res = cnt + 1'b1;
    end else if (down && !up) begin
      res = cnt - 1'b1;
    end
    return res;
  endfunction

  assign ld_accept = issue_accept_i && (issue_op_i == ACC_OP_LOAD);
  assign st_accept = issue_accept_i && (issue_op_i == ACC_OP_STORE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      spec_ld_q <= '0;
      spec_st_q <= '0;
      disp_ld_q <= '0;
      disp_st_q <= '0;
    end else begin
      // Speculative entries can still be flushed
      spec_ld_q <= flush_i ? '0 : step(spec_ld_q, ld_accept, ld_disp_i);
      spec_st_q <= flush_i ? '0 : step(spec_st_q, st_accept, st_disp_i);
      // Dispatched ones only leave on completion
      disp_ld_q <= step(disp_ld_q, ld_disp_i, load_complete_i);
      disp_st_q <= step(disp_st_q, st_disp_i, store_complete_i);
    end
  end

  assign ld_pending = (spec_ld_q != '0) || (disp_ld_q != '0);
  assign st_pending = (spec_st_q != '0) || (disp_st_q != '0);

  // Scalar loads wait for stores, scalar stores wait for both
  always_comb begin
    case (issue_fu_i)
      FU_LOAD:  mem_stall_o = cons_en_i && st_pending;
      FU_STORE: mem_stall_o = cons_en_i && (ld_pending || st_pending);
      default:  mem_stall_o = 1'b0;
    endcase
  end

  // Barrier halt is set by the barrier, held until stores drain
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_st_q <= 1'b0;
    end else begin
      wait_st_q <= (wait_st_q || st_barrier_i) && store_pending_i;
    end
  end

  assign halt_o = wait_st_q;

endmodule

// File: src/acc_req_stage.sv
/*
 * Builds the coprocessor request from the queue head and the live rounding
 * mode. A one-entry fall-through register absorbs back-pressure from the
 * coprocessor, popping the queue and flagging dispatched loads and stores.
 */
module acc_req_stage #(
  parameter int unsigned QUEUE_DEPTH = 3
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   head_valid_i,
  input  logic                                   head_ready_i,
  input  acc_disp_pkg::acc_op_e                  head_op_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] head_trans_id_i,
  input  logic [acc_disp_pkg::INSN_W-1:0]        head_insn_i,
  input  logic [acc_disp_pkg::XLEN-1:0]          head_rs1_i,
  input  logic [acc_disp_pkg::XLEN-1:0]          head_rs2_i,
  input  acc_disp_pkg::frm_t                     frm_i,
  output logic                                   pop_o,
  output logic                                   ld_disp_o,
  output logic                                   st_disp_o,
  output logic                                   acc_req_valid_o,
  output logic [acc_disp_pkg::INSN_W-1:0]        acc_req_insn_o,
  output logic [acc_disp_pkg::XLEN-1:0]          acc_req_rs1_o,
  output logic [acc_disp_pkg::XLEN-1:0]          acc_req_rs2_o,
  output acc_disp_pkg::frm_t                     acc_req_frm_o,
  output logic [acc_disp_pkg::TRANS_ID_BITS-1:0] acc_req_trans_id_o,
  input  logic                                   acc_req_ready_i
);
  import acc_disp_pkg::*;

  // Queue plus output register must never hold two live uses of one ID
  if (QUEUE_DEPTH + 1 > NR_SB_ENTRIES) begin : g_depth_check
    $fatal(1, "queue depth exceeds the scoreboard transaction ID space");
  end

  logic                     fire;
  logic                     full_q;
  logic [INSN_W-1:0]        insn_q;
  logic [XLEN-1:0]          rs1_q, rs2_q;
  frm_t                     frm_q;
  logic [TRANS_ID_BITS-1:0] id_q;

  // Head may leave only once it is non-speculative
  assign fire  = head_valid_i && head_ready_i;
  assign pop_o = fire && !full_q;

  assign ld_disp_o = pop_o && (head_op_i == ACC_OP_LOAD);
  assign st_disp_o = pop_o && (head_op_i == ACC_OP_STORE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      full_q <= !acc_req_ready_i;
    end else begin
      // Park the request when the coprocessor refuses it
      full_q <= fire && !acc_req_ready_i;
    end
  end

  // frm is sampled when the request leaves the queue
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      insn_q <= head_insn_i;
      rs1_q  <= head_rs1_i;
      rs2_q  <= head_rs2_i;
      frm_q  <= frm_i;
      id_q   <= head_trans_id_i;
    end
  end

  // Empty register passes the head straight through
  assign acc_req_valid_o    = full_q || fire;
  assign acc_req_insn_o     = full_q ? insn_q : head_insn_i;
  assign acc_req_rs1_o      = full_q ? rs1_q  : head_rs1_i;
  assign acc_req_rs2_o      = full_q ? rs2_q  : head_rs2_i;
  assign acc_req_frm_o      = full_q ? frm_q  : frm_i;
  assign acc_req_trans_id_o = full_q ? id_q   : head_trans_id_i;

endmodule

// File: src/acc_disp_top.sv
/*
 * Accelerator dispatch unit for an in-order core.
 * Queues accelerator instructions from issue, sends them to the coprocessor
 * once committed, returns results and errors, and guards memory ordering.
 */
module acc_disp_top #(
  parameter int unsigned QUEUE_DEPTH = 3,
  parameter int unsigned CNT_WIDTH   = 3
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   cons_en_i,
  input  acc_disp_pkg::frm_t                     frm_i,
  output logic                                   dirty_v_state_o,
  // Issue stage
  input  acc_disp_pkg::fu_e                      issue_fu_i,
  input  acc_disp_pkg::acc_op_e                  issue_op_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] issue_trans_id_i,
  input  logic [acc_disp_pkg::INSN_W-1:0]        issue_insn_i,
  input  logic [acc_disp_pkg::XLEN-1:0]          issue_rs1_i,
  input  logic [acc_disp_pkg::XLEN-1:0]          issue_rs2_i,
  input  logic                                   issue_hs_i,
  output logic                                   issue_stall_o,
  // Commit stage and controller
  input  logic                                   commit_acc_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] commit_trans_id_i,
  input  logic                                   commit_ack_i,
  input  logic                                   commit_st_barrier_i,
  input  logic                                   flush_i,
  input  logic                                   flush_unissued_i,
  input  logic                                   lsu_no_st_pending_i,
  output logic                                   halt_o,
  // Results back to the core
  output logic                                   result_valid_o,
  output logic [acc_disp_pkg::TRANS_ID_BITS-1:0] result_trans_id_o,
  output logic [acc_disp_pkg::XLEN-1:0]          result_o,
  output logic                                   exc_valid_o,
  output logic [acc_disp_pkg::XLEN-1:0]          exc_cause_o,
  // Coprocessor request
  output logic                                   acc_req_valid_o,
  output logic [acc_disp_pkg::INSN_W-1:0]        acc_req_insn_o,
  output logic [acc_disp_pkg::XLEN-1:0]          acc_req_rs1_o,
  output logic [acc_disp_pkg::XLEN-1:0]          acc_req_rs2_o,
  output acc_disp_pkg::frm_t                     acc_req_frm_o,
  output logic [acc_disp_pkg::TRANS_ID_BITS-1:0] acc_req_trans_id_o,
  output logic                                   acc_req_store_pending_o,
  input  logic                                   acc_req_ready_i,
  // Coprocessor response
  input  logic                                   acc_resp_valid_i,
  input  logic [acc_disp_pkg::TRANS_ID_BITS-1:0] acc_resp_trans_id_i,
  input  logic [acc_disp_pkg::XLEN-1:0]          acc_resp_result_i,
  input  logic                                   acc_resp_error_i,
  input  logic                                   acc_load_complete_i,
  input  logic                                   acc_store_complete_i,
  input  logic                                   acc_store_pending_i
);
  import acc_disp_pkg::*;

  localparam int unsigned USAGE_W = $clog2(QUEUE_DEPTH+1);

  logic                     accept_d, accept_q;
  acc_op_e                  op_q;
  logic [TRANS_ID_BITS-1:0] id_q;
  logic [INSN_W-1:0]        insn_q;
  logic [XLEN-1:0]          rs1_q, rs2_q;

  logic                     q_empty, q_pop;
  logic [USAGE_W-1:0]       q_usage;
  acc_op_e                  head_op;
  logic [TRANS_ID_BITS-1:0] head_id;
  logic [INSN_W-1:0]        head_insn;
  logic [XLEN-1:0]          head_rs1, head_rs2;
  logic                     head_ready, ld_disp, st_disp, mem_stall, queue_full;

  // Accepted accelerator instruction, skipped if its issue is flushed
  assign accept_d = issue_hs_i && (issue_fu_i == FU_ACCEL) && !flush_unissued_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= accept_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_d) begin
      op_q   <= issue_op_i;
      id_q   <= issue_trans_id_i;
      insn_q <= issue_insn_i;
      rs1_q  <= issue_rs1_i;
      rs2_q  <= issue_rs2_i;
    end
  end

  acc_insn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
    .push_i(accept_q), .push_op_i(op_q), .push_trans_id_i(id_q),
    .push_insn_i(insn_q), .push_rs1_i(rs1_q), .push_rs2_i(rs2_q),
    .pop_i(q_pop), .empty_o(q_empty), .usage_o(q_usage),
    .head_op_o(head_op), .head_trans_id_o(head_id), .head_insn_o(head_insn),
    .head_rs1_o(head_rs1), .head_rs2_o(head_rs2)
  );

  acc_spec_tracker u_spec (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
    .recv_i(accept_q), .recv_trans_id_i(id_q),
    .commit_i(commit_acc_i), .commit_trans_id_i(commit_trans_id_i),
    .dispatch_i(q_pop), .dispatch_trans_id_i(head_id),
    .query_trans_id_i(head_id), .ready_o(head_ready)
  );

  acc_req_stage #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_req (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .head_valid_i(!q_empty), .head_ready_i(head_ready), .head_op_i(head_op),
    .head_trans_id_i(head_id), .head_insn_i(head_insn),
    .head_rs1_i(head_rs1), .head_rs2_i(head_rs2), .frm_i(frm_i),
    .pop_o(q_pop), .ld_disp_o(ld_disp), .st_disp_o(st_disp),
    .acc_req_valid_o(acc_req_valid_o), .acc_req_insn_o(acc_req_insn_o),
    .acc_req_rs1_o(acc_req_rs1_o), .acc_req_rs2_o(acc_req_rs2_o),
    .acc_req_frm_o(acc_req_frm_o), .acc_req_trans_id_o(acc_req_trans_id_o),
    .acc_req_ready_i(acc_req_ready_i)
  );

  acc_mem_tracker #(.CNT_WIDTH(CNT_WIDTH)) u_mem (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i), .cons_en_i(cons_en_i),
    .issue_fu_i(issue_fu_i), .issue_accept_i(accept_d), .issue_op_i(issue_op_i),
    .ld_disp_i(ld_disp), .st_disp_i(st_disp),
    .load_complete_i(acc_load_complete_i), .store_complete_i(acc_store_complete_i),
    .store_pending_i(acc_store_pending_i), .st_barrier_i(commit_st_barrier_i),
    .mem_stall_o(mem_stall), .halt_o(halt_o)
  );

  // One slot is kept free for the instruction still in the accept register
  assign queue_full    = (q_usage >= USAGE_W'(QUEUE_DEPTH - 1));
  assign issue_stall_o = (issue_fu_i == FU_ACCEL) ? queue_full : mem_stall;

  // Scalar LSU stores still in flight, seen by the coprocessor
  assign acc_req_store_pending_o = cons_en_i && !lsu_no_st_pending_i;

  // Acks on this port only retire accelerator instructions
  assign dirty_v_state_o = commit_ack_i;

  // Response path, no buffering
  assign result_valid_o    = acc_resp_valid_i;
  assign result_trans_id_o = acc_resp_trans_id_i;
  assign result_o          = acc_resp_result_i;
  assign exc_valid_o       = acc_resp_error_i;
  assign exc_cause_o       = EXC_ILLEGAL_INSN;

endmodule

// File: verif/acc_disp_tb_util.svh
/*
 * Driver, compare and bounded-wait tasks for the dispatch unit testbench.
 * Included into the testbench module body and drives its signals directly.
 * Drivers start and end at the drive point, 2 units after a rising edge.
 */
`ifndef ACC_DISP_TB_UTIL_SVH
`define ACC_DISP_TB_UTIL_SVH

// Advance to the drive point of the next cycle
task automatic next_cycle();
  @(posedge clk_i);
  #2;
endtask

function automatic logic [XLEN-1:0] rand_word();
  return {$urandom, $urandom};
endfunction

task automatic check_word(input string what, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("Error in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
  end
endtask

task automatic check_id(input string what, input logic [TRANS_ID_BITS-1:0] exp,
                        input logic [TRANS_ID_BITS-1:0] act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("Error in %s (%s): expected %0d, actual %0d", cur_test, what, exp, act);
  end
endtask

task automatic check_frm(input string what, input frm_t exp, input frm_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("Error in %s (%s): expected %0d, actual %0d", cur_test, what, exp, act);
  end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("Error in %s (%s): expected %b, actual %b", cur_test, what, exp, act);
  end
endtask

// Present a functional unit for one cycle and sample the stall mid-cycle
task automatic stall_for(input fu_e fu, input logic exp);
  issue_fu_i = fu;
  @(negedge clk_i);
  check_bit($sformatf("issue stall for fu %0d", fu), exp, issue_stall_o);
  next_cycle();
  issue_fu_i = FU_NONE;
endtask

// Returns once the instruction sits in the queue and is pending
task automatic issue_insn(input fu_e fu, input acc_op_e op,
                          input logic [TRANS_ID_BITS-1:0] id,
                          input logic [INSN_W-1:0] insn,
                          input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2);
  issue_fu_i       = fu;
  issue_op_i       = op;
  issue_trans_id_i = id;
  issue_insn_i     = insn;
  issue_rs1_i      = rs1;
  issue_rs2_i      = rs2;
  issue_hs_i       = 1'b1;
  @(negedge clk_i);
  check_bit("stall before issue", 1'b0, issue_stall_o);
  next_cycle();
  issue_hs_i = 1'b0;
  issue_fu_i = FU_NONE;
  next_cycle();
endtask

// Single-cycle commit strobe
task automatic commit_insn(input logic [TRANS_ID_BITS-1:0] id);
  commit_acc_i      = 1'b1;
  commit_trans_id_i = id;
  next_cycle();
  commit_acc_i = 1'b0;
endtask

// Stops on the first mid-cycle sample with a valid request
task automatic wait_req_valid(output logic found);
  int n;
  found = 1'b0;
  n = 0;
  while (!found && n < REQ_TIMEOUT) begin
    @(negedge clk_i);
    found = acc_req_valid_o;
    n++;
  end
  if (!found) begin
    errors++;
    $display("Timeout in %s: no coprocessor request after %0d cycles", cur_test, n);
  end
endtask

// Commit held until the request shows, a ready coprocessor takes it at the next edge
task automatic commit_and_dispatch(input logic [TRANS_ID_BITS-1:0] id);
  logic found;
  commit_acc_i      = 1'b1;
  commit_trans_id_i = id;
  wait_req_valid(found);
  if (found) begin
    check_id("dispatched id", id, acc_req_trans_id_o);
  end
  next_cycle();
  commit_acc_i = 1'b0;
endtask

`endif

// File: verif/acc_disp_tb.sv
/*
 * Directed testbench for the accelerator dispatch unit.
 * Plays issue stage, commit stage, controller and coprocessor around the DUT,
 * runs one task per behavior and prints an error count at the end.
 */
module acc_disp_tb;
  import acc_disp_pkg::*;

  localparam int unsigned REQ_TIMEOUT = 50;
  // Cause code for a coprocessor error
  localparam logic [XLEN-1:0] ILLEGAL_CAUSE = 64'd2;

  logic clk_i, rst_n_i, cons_en_i, dirty_v_state_o;
  frm_t frm_i;
  fu_e issue_fu_i;
  acc_op_e issue_op_i;
  logic [TRANS_ID_BITS-1:0] issue_trans_id_i, commit_trans_id_i, result_trans_id_o;
  logic [TRANS_ID_BITS-1:0] acc_req_trans_id_o, acc_resp_trans_id_i;
  logic [INSN_W-1:0] issue_insn_i, acc_req_insn_o;
  logic [XLEN-1:0] issue_rs1_i, issue_rs2_i, result_o, exc_cause_o;
  logic [XLEN-1:0] acc_req_rs1_o, acc_req_rs2_o, acc_resp_result_i;
  logic issue_hs_i, issue_stall_o, commit_acc_i, commit_ack_i, commit_st_barrier_i;
  logic flush_i, flush_unissued_i, lsu_no_st_pending_i, halt_o;
  logic result_valid_o, exc_valid_o, acc_req_valid_o, acc_req_store_pending_o;
  frm_t acc_req_frm_o;
  logic acc_req_ready_i, acc_resp_valid_i, acc_resp_error_i;
  logic acc_load_complete_i, acc_store_complete_i, acc_store_pending_i;

  int    errors;
  int    checks;
  string cur_test;

  `include "acc_disp_tb_util.svh"

  acc_disp_top #(.QUEUE_DEPTH(3), .CNT_WIDTH(3)) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic reset_state();
    cur_test = "reset_state";
    @(negedge clk_i);
    check_bit("request valid", 1'b0, acc_req_valid_o);
    check_bit("halt", 1'b0, halt_o);
    next_cycle();
    stall_for(FU_NONE, 1'b0);
    stall_for(FU_LOAD, 1'b0);
    stall_for(FU_STORE, 1'b0);
    stall_for(FU_ACCEL, 1'b0);
  endtask

  task automatic nonspec_dispatch();
    logic [INSN_W-1:0] insn;
    logic [XLEN-1:0]   rs1, rs2;
    frm_t              frm;
    logic              found;
    cur_test = "nonspec_dispatch";
    insn = $urandom;
    rs1  = rand_word();
    rs2  = rand_word();
    issue_insn(FU_ACCEL, ACC_OP_COMPUTE, 3'd1, insn, rs1, rs2);
    // Speculative, so nothing may leave
    repeat (10) begin
      @(negedge clk_i);
      check_bit("request before commit", 1'b0, acc_req_valid_o);
      next_cycle();
    end
    frm   = frm_t'($urandom);
    frm_i = frm;
    commit_acc_i      = 1'b1;
    commit_trans_id_i = 3'd1;
    wait_req_valid(found);
    if (found) begin
      check_word("req insn", XLEN'(insn), XLEN'(acc_req_insn_o));
      check_word("req rs1", rs1, acc_req_rs1_o);
      check_word("req rs2", rs2, acc_req_rs2_o);
      check_id("req trans id", 3'd1, acc_req_trans_id_o);
      check_frm("req frm", frm, acc_req_frm_o);
    end
    next_cycle();
    commit_acc_i = 1'b0;
    @(negedge clk_i);
    check_bit("request after transfer", 1'b0, acc_req_valid_o);
    next_cycle();
  endtask

  task automatic flush_drops_queue();
    cur_test = "flush_drops_queue";
    // Any stray request would park and stay visible
    acc_req_ready_i = 1'b0;
    issue_insn(FU_ACCEL, ACC_OP_LOAD, 3'd2, $urandom, rand_word(), rand_word());
    issue_insn(FU_ACCEL, ACC_OP_STORE, 3'd3, $urandom, rand_word(), rand_word());
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    commit_insn(3'd2);
    commit_insn(3'd3);
    repeat (5) begin
      @(negedge clk_i);
      check_bit("request after flush", 1'b0, acc_req_valid_o);
      next_cycle();
    end
    stall_for(FU_ACCEL, 1'b0);
    acc_req_ready_i = 1'b1;
  endtask

  task automatic back_pressure();
    logic [INSN_W-1:0]        insn [3];
    logic [TRANS_ID_BITS-1:0] got_id [$];
    logic [INSN_W-1:0]        got_insn [$];
    int                       i;
    logic                     found;
    cur_test = "back_pressure";
    for (i = 0; i < 3; i++) begin
      insn[i] = $urandom;
    end
    acc_req_ready_i = 1'b0;
    issue_insn(FU_ACCEL, ACC_OP_COMPUTE, 3'd4, insn[0], rand_word(), rand_word());
    commit_insn(3'd4);
    // Refused request parks in the output register
    wait_req_valid(found);
    if (found) begin
      check_id("parked id", 3'd4, acc_req_trans_id_o);
    end
    next_cycle();
    issue_insn(FU_ACCEL, ACC_OP_COMPUTE, 3'd5, insn[1], rand_word(), rand_word());
    issue_insn(FU_ACCEL, ACC_OP_COMPUTE, 3'd6, insn[2], rand_word(), rand_word());
    commit_insn(3'd5);
    commit_insn(3'd6);
    // Request held stable behind the refusing coprocessor
    @(negedge clk_i);
    check_bit("held valid", 1'b1, acc_req_valid_o);
    check_id("held id", 3'd4, acc_req_trans_id_o);
    check_word("held insn", XLEN'(insn[0]), XLEN'(acc_req_insn_o));
    next_cycle();
    stall_for(FU_ACCEL, 1'b1);
    acc_req_ready_i = 1'b1;
    for (i = 0; i < REQ_TIMEOUT && got_id.size() < 3; i++) begin
      @(negedge clk_i);
      if (acc_req_valid_o) begin
        got_id.push_back(acc_req_trans_id_o);
        got_insn.push_back(acc_req_insn_o);
      end
    end
    if (got_id.size() < 3) begin
      errors++;
      $display("Timeout in %s: only %0d of 3 requests drained", cur_test, got_id.size());
    end else begin
      for (i = 0; i < 3; i++) begin
        check_id("drain order id", TRANS_ID_BITS'(4 + i), got_id[i]);
        check_word("drain order insn", XLEN'(insn[i]), XLEN'(got_insn[i]));
      end
    end
    next_cycle();
    stall_for(FU_ACCEL, 1'b0);
  endtask

  task automatic mem_consistency();
    cur_test = "mem_consistency";
    cons_en_i           = 1'b1;
    lsu_no_st_pending_i = 1'b0;
    @(negedge clk_i);
    check_bit("lsu store pending", 1'b1, acc_req_store_pending_o);
    next_cycle();
    lsu_no_st_pending_i = 1'b1;
    @(negedge clk_i);
    check_bit("lsu stores drained", 1'b0, acc_req_store_pending_o);
    next_cycle();
    stall_for(FU_LOAD, 1'b0);
    issue_insn(FU_ACCEL, ACC_OP_STORE, 3'd7, $urandom, rand_word(), rand_word());
    stall_for(FU_LOAD, 1'b1);
    stall_for(FU_STORE, 1'b1);
    commit_and_dispatch(3'd7);
    // Dispatched store still outstanding
    stall_for(FU_LOAD, 1'b1);
    acc_store_complete_i = 1'b1;
    next_cycle();
    acc_store_complete_i = 1'b0;
    stall_for(FU_LOAD, 1'b0);
    stall_for(FU_STORE, 1'b0);
    cons_en_i = 1'b0;
    issue_insn(FU_ACCEL, ACC_OP_STORE, 3'd0, $urandom, rand_word(), rand_word());
    stall_for(FU_LOAD, 1'b0);
    stall_for(FU_STORE, 1'b0);
    commit_and_dispatch(3'd0);
    acc_store_complete_i = 1'b1;
    next_cycle();
    acc_store_complete_i = 1'b0;
  endtask

  task automatic store_barrier_halt();
    cur_test = "store_barrier_halt";
    // No coprocessor store pending, barrier passes
    commit_st_barrier_i = 1'b1;
    next_cycle();
    commit_st_barrier_i = 1'b0;
    @(negedge clk_i);
    check_bit("halt without pending store", 1'b0, halt_o);
    next_cycle();
    acc_store_pending_i = 1'b1;
    commit_st_barrier_i = 1'b1;
    @(negedge clk_i);
    check_bit("halt in barrier cycle", 1'b0, halt_o);
    next_cycle();
    commit_st_barrier_i = 1'b0;
    repeat (3) begin
      @(negedge clk_i);
      check_bit("halt while store pending", 1'b1, halt_o);
      next_cycle();
    end
    acc_store_pending_i = 1'b0;
    @(negedge clk_i);
    check_bit("halt in release cycle", 1'b1, halt_o);
    next_cycle();
    @(negedge clk_i);
    check_bit("halt after release", 1'b0, halt_o);
    next_cycle();
  endtask

  task automatic response_passthrough();
    logic [TRANS_ID_BITS-1:0] id;
    logic [XLEN-1:0]          res;
    cur_test = "response_passthrough";
    id  = TRANS_ID_BITS'($urandom);
    res = rand_word();
    acc_resp_valid_i    = 1'b1;
    acc_resp_trans_id_i = id;
    acc_resp_result_i   = res;
    @(negedge clk_i);
    check_bit("result valid", 1'b1, result_valid_o);
    check_id("result id", id, result_trans_id_o);
    check_word("result", res, result_o);
    check_bit("exception without error", 1'b0, exc_valid_o);
    next_cycle();
    acc_resp_error_i = 1'b1;
    @(negedge clk_i);
    check_bit("exception valid", 1'b1, exc_valid_o);
    check_word("exception cause", ILLEGAL_CAUSE, exc_cause_o);
    next_cycle();
    acc_resp_valid_i = 1'b0;
    acc_resp_error_i = 1'b0;
    commit_ack_i     = 1'b1;
    @(negedge clk_i);
    check_bit("result idle", 1'b0, result_valid_o);
    check_bit("dirty on ack", 1'b1, dirty_v_state_o);
    next_cycle();
    commit_ack_i = 1'b0;
    @(negedge clk_i);
    check_bit("dirty without ack", 1'b0, dirty_v_state_o);
    next_cycle();
  endtask

  initial begin
    int unsigned seed_val;
    errors   = 0;
    checks   = 0;
    cur_test = "init";
    seed_val = $urandom(32'h31be7b46);
    rst_n_i             = 1'b0;
    cons_en_i           = 1'b0;
    frm_i               = '0;
    issue_fu_i          = FU_NONE;
    issue_op_i          = ACC_OP_COMPUTE;
    issue_trans_id_i    = '0;
    issue_insn_i        = '0;
    issue_rs1_i         = '0;
    issue_rs2_i         = '0;
    issue_hs_i          = 1'b0;
    commit_acc_i        = 1'b0;
    commit_trans_id_i   = '0;
    commit_ack_i        = 1'b0;
    commit_st_barrier_i = 1'b0;
    flush_i             = 1'b0;
    flush_unissued_i    = 1'b0;
    lsu_no_st_pending_i = 1'b1;
    acc_req_ready_i     = 1'b1;
    acc_resp_valid_i    = 1'b0;
    acc_resp_trans_id_i = '0;
    acc_resp_result_i   = '0;
    acc_resp_error_i    = 1'b0;
    acc_load_complete_i = 1'b0;
    acc_store_complete_i = 1'b0;
    acc_store_pending_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    reset_state();
    nonspec_dispatch();
    flush_drops_queue();
    back_pressure();
    mem_consistency();
    store_barrier_halt();
    response_passthrough();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: acc_disp.f
+incdir+verif
src/acc_disp_pkg.sv
src/acc_insn_queue.sv
src/acc_spec_tracker.sv
src/acc_mem_tracker.sv
src/acc_req_stage.sv
src/acc_disp_top.sv
verif/acc_disp_tb.sv
